/* hdl/refTickGen.sv */
//********************************************************************
// reference clock synchronizer and rising-edge detector
// produces one clk-wide tick per refClk rising edge
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module refTickGen (
    input  logic clk,
    input  logic reset,
    input  logic refClk,
    output logic tick
);

    logic [regMapPkg::SYNC_STAGES-1:0] syncReg;
    logic                              prevLevel;

    // refClk is asynchronous to clk, first stage may go metastable
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            syncReg   <= '0;
            prevLevel <= 1'b0;
            tick      <= 1'b0;
        end else begin
            syncReg   <= {syncReg[regMapPkg::SYNC_STAGES-2:0], refClk};
            prevLevel <= syncReg[regMapPkg::SYNC_STAGES-1];
            // high for one cycle when the synchronized level goes 0 -> 1
            tick      <= syncReg[regMapPkg::SYNC_STAGES-1] & ~prevLevel;
        end
    end

endmodule

`default_nettype wire

/* hdl/regMapPkg.sv */
//********************************************************************
// register map of the timer bus and bus field types
// word address constants, synchronizer depth of the tick path
//********************************************************************

`default_nettype none

package regMapPkg;

    // bus fields
    typedef logic [2:0]  regAddr_t;
    typedef logic [31:0] busWord_t;

    // word addresses, address 7 is unused and reads as zero
    localparam regAddr_t ADDR_COUNT0  = 3'd0;
    localparam regAddr_t ADDR_COUNT1  = 3'd1;
    localparam regAddr_t ADDR_COUNT2  = 3'd2;
    localparam regAddr_t ADDR_RELOAD0 = 3'd3;
    localparam regAddr_t ADDR_RELOAD1 = 3'd4;
    localparam regAddr_t ADDR_RELOAD2 = 3'd5;
    localparam regAddr_t ADDR_IRQ_EN  = 3'd6;

    // flops between refClk and the edge detector, sets tick latency
    localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

/* hdl/timerBusRegs.sv */
//********************************************************************
// bus front end of the timer
// request registers, write decoder and registered read multiplexer
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module timerBusRegs (
    input  logic                clk,
    input  logic                reset,
    input  logic                read,
    input  logic                write,
    input  regMapPkg::regAddr_t address,
    input  regMapPkg::busWord_t dataIn,
    output logic                readValid,
    output regMapPkg::busWord_t dataOut,
    timerRegIf.bus              regs
);

    logic                readReg;
    logic                writeReg;
    regMapPkg::regAddr_t addressReg;
    regMapPkg::busWord_t dataInReg;
    regMapPkg::busWord_t readMux;

    // request stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readReg    <= 1'b0;
            writeReg   <= 1'b0;
            addressReg <= '0;
            dataInReg  <= '0;
        end else begin
            readReg    <= read;
            writeReg   <= write;
            addressReg <= address;
            dataInReg  <= dataIn;
        end
    end

    // response stage, two edges after the request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readValid <= 1'b0;
            dataOut   <= '0;
        end else begin
            readValid <= readReg;
            dataOut   <= readMux;
        end
    end

    assign regs.wrData = dataInReg;

    // write decoder, at most one strobe per cycle
    always_comb begin
        regs.countLoad  = '0;
        regs.reloadLoad = '0;
        regs.irqEnLoad  = 1'b0;
        if (writeReg) begin
            case (addressReg)
                regMapPkg::ADDR_COUNT0:  regs.countLoad[0]  = 1'b1;
                regMapPkg::ADDR_COUNT1:  regs.countLoad[1]  = 1'b1;
                regMapPkg::ADDR_COUNT2:  regs.countLoad[2]  = 1'b1;
                regMapPkg::ADDR_RELOAD0: regs.reloadLoad[0] = 1'b1;
                regMapPkg::ADDR_RELOAD1: regs.reloadLoad[1] = 1'b1;
                regMapPkg::ADDR_RELOAD2: regs.reloadLoad[2] = 1'b1;
                regMapPkg::ADDR_IRQ_EN:  regs.irqEnLoad     = 1'b1;
                default: ;
            endcase
        end
    end

    // read mux, unused enable bits come back as zero
    always_comb begin
        readMux = '0;
        case (addressReg)
            regMapPkg::ADDR_COUNT0:  readMux = regs.count[0];
            regMapPkg::ADDR_COUNT1:  readMux = regs.count[1];
            regMapPkg::ADDR_COUNT2:  readMux = regs.count[2];
            regMapPkg::ADDR_RELOAD0: readMux = regs.reload[0];
            regMapPkg::ADDR_RELOAD1: readMux = regs.reload[1];
            regMapPkg::ADDR_RELOAD2: readMux = regs.reload[2];
            regMapPkg::ADDR_IRQ_EN:  readMux = regMapPkg::busWord_t'(regs.irqEn);
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/timerChannel.sv */
//********************************************************************
// one timer channel
// count and reload registers, decrement on tick, reload at zero
// and a one-cycle interrupt pulse when enabled
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module timerChannel (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  logic                 countLoad,
    input  logic                 reloadLoad,
    input  timerPkg::timerWord_t wrData,
    input  logic                 irqEnable,
    output timerPkg::timerWord_t count,
    output timerPkg::timerWord_t reload,
    output logic                 irq
);

    logic countZero;

    assign countZero = (count == '0);

    // bus write to the count wins over a tick in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (countLoad) begin
            count <= wrData;
        end else if (tick) begin
            if (countZero) begin
                count <= reload;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reload <= '0;
        end else if (reloadLoad) begin
            reload <= wrData;
        end
    end

    // pulse only when the reload really happens
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            irq <= 1'b0;
        end else begin
            irq <= tick & countZero & irqEnable & ~countLoad;
        end
    end

endmodule

`default_nettype wire

/* hdl/timerCore.sv */
//********************************************************************
// timer core
// NUM_TIMERS channels and the interrupt enable register
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module timerCore (
    input  logic              clk,
    input  logic              reset,
    input  logic              tick,
    timerRegIf.core           regs,
    output timerPkg::irqVec_t irq
);

    timerPkg::irqVec_t irqEnReg;

    // enable mask comes from the low bits of the write word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            irqEnReg <= '0;
        end else if (regs.irqEnLoad) begin
            irqEnReg <= regs.wrData[timerPkg::NUM_TIMERS-1:0];
        end
    end

    assign regs.irqEn = irqEnReg;

    // all channels share the tick and the write data
    for (genvar i = 0; i < timerPkg::NUM_TIMERS; i++) begin : genChannel
        timerChannel i_timerChannel (
            .clk        (clk),
            .reset      (reset),
            .tick       (tick),
            .countLoad  (regs.countLoad[i]),
            .reloadLoad (regs.reloadLoad[i]),
            .wrData     (regs.wrData),
            .irqEnable  (irqEnReg[i]),
            .count      (regs.count[i]),
            .reload     (regs.reload[i]),
            .irq        (irq[i])
        );
    end

endmodule

`default_nettype wire

/* hdl/timerPkg.sv */
//********************************************************************
// timer data types shared by the channels, the core and the bus block
// count/reload word type, interrupt vector type, channel count
//********************************************************************

`default_nettype none

package timerPkg;

    // number of independent down counters
    localparam int NUM_TIMERS = 3;

    // width of one count or reload register
    localparam int TIMER_WIDTH = 32;

    // count and reload value
    typedef logic [TIMER_WIDTH-1:0] timerWord_t;

    // one bit per channel, used for enables, strobes and irq
    typedef logic [NUM_TIMERS-1:0] irqVec_t;

endpackage

`default_nettype wire

/* hdl/timerRegIf.sv */
//********************************************************************
// register interface between the bus front end and the timer core
// write data and load strobes toward the core, readbacks back
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

interface timerRegIf;

    // write side, driven by the bus block
    timerPkg::timerWord_t wrData;
    timerPkg::irqVec_t    countLoad;
    timerPkg::irqVec_t    reloadLoad;
    logic                 irqEnLoad;

    // readback side, driven by the core
    timerPkg::timerWord_t count  [timerPkg::NUM_TIMERS];
    timerPkg::timerWord_t reload [timerPkg::NUM_TIMERS];
    timerPkg::irqVec_t    irqEn;

    modport bus (
        output wrData, countLoad, reloadLoad, irqEnLoad,
        input  count, reload, irqEn
    );

    modport core (
        input  wrData, countLoad, reloadLoad, irqEnLoad,
        output count, reload, irqEn
    );

endinterface

`default_nettype wire

/* hdl/timerTop.sv */
//********************************************************************
// timer peripheral top level
// bus front end, reference tick generator and timer core
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module timerTop (
    input  logic                clk,
    input  logic                reset,
    input  logic                read,
    input  logic                write,
    input  regMapPkg::regAddr_t address,
    input  regMapPkg::busWord_t dataIn,
    input  logic                refClk,
    output logic                readValid,
    output regMapPkg::busWord_t dataOut,
    output timerPkg::irqVec_t   irq
);

    logic tick;

    timerRegIf regIf ();

    timerBusRegs i_timerBusRegs (
        .clk       (clk),
        .reset     (reset),
        .read      (read),
        .write     (write),
        .address   (address),
        .dataIn    (dataIn),
        .readValid (readValid),
        .dataOut   (dataOut),
        .regs      (regIf.bus)
    );

    refTickGen i_refTickGen (
        .clk    (clk),
        .reset  (reset),
        .refClk (refClk),
        .tick   (tick)
    );

    timerCore i_timerCore (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .regs  (regIf.core),
        .irq   (irq)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/bash
# compile the timer testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module tbTimer -f tb.f -o simTimer \
    && ./obj_dir/simTimer | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }

/* tb.f */
hdl/timerPkg.sv
hdl/regMapPkg.sv
hdl/timerRegIf.sv
hdl/timerBusRegs.sv
hdl/refTickGen.sv
hdl/timerChannel.sv
hdl/timerCore.sv
hdl/timerTop.sv
verif/timerChecker.sv
verif/tbTimer.sv

/* verif/tbTimer.sv */
//**********************************************************************
// timer peripheral testbench top
// clock and reset, stimulus table walk, bus and refClk drivers
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

module tbTimer;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_READB, OP_PULSE, OP_IRQ} op_t;

    typedef struct packed {
        logic [127:0] name;
        op_t          op;
        logic [2:0]   addr;
        logic [31:0]  data;
        logic [31:0]  expected;
    } entry_t;

    logic                clk = 1'b0;
    logic                reset, read, write, refClk, readValid, checkIrq;
    regMapPkg::regAddr_t address;
    regMapPkg::busWord_t dataIn, dataOut, expWord;
    timerPkg::irqVec_t   irq;
    logic [127:0]        testName;
    int                  passCount, failCount, timeouts, pending, seed;
    entry_t              stimTable[$];
    logic [31:0]         rnd [6];

    always #20 clk = ~clk;

    timerTop i_timerTop (
        .clk(clk), .reset(reset), .read(read), .write(write), .address(address),
        .dataIn(dataIn), .refClk(refClk), .readValid(readValid), .dataOut(dataOut), .irq(irq)
    );

    timerChecker i_timerChecker (
        .clk(clk), .reset(reset), .read(read), .readValid(readValid), .dataOut(dataOut),
        .irq(irq), .checkIrq(checkIrq), .chan(address[1:0]), .testName(testName),
        .expWord(expWord), .passCount(passCount), .failCount(failCount)
    );

    task automatic addRow(input logic [127:0] name, input op_t op, input int addr,
                          input logic [31:0] data, input logic [31:0] expected);
        stimTable.push_back('{name, op, 3'(addr), data, expected});
    endtask

    // count after a number of ticks, from the decrement and reload rules
    function automatic logic [31:0] countAfter(input logic [31:0] start,
                                               input logic [31:0] reloadVal, input int ticks);
        logic [31:0] c;
        c = start;
        repeat (ticks) c = (c == 0) ? reloadVal : c - 1;
        return c;
    endfunction

    // each refClk half period lasts four clk cycles
    task automatic refPulses(input int n);
        repeat (2 * n) begin
            repeat (4) @(posedge clk);
            #2;
            refClk = ~refClk;
        end
        for (int c = 0; c < 4; c++) @(posedge clk);
    endtask

    task automatic waitReads();
        int cycles;
        cycles = 0;
        while (pending > 0 && cycles < 20) begin
            @(posedge clk);
            if (readValid) pending--;
            #2;
            read = 1'b0;
            cycles++;
        end
        if (pending > 0) begin
            $display("timeout waiting for read data");
            timeouts++;
            pending = 0;
        end
    endtask

    task automatic runEntry(input entry_t e);
        @(posedge clk);
        // responses to earlier back-to-back reads arrive while the table moves on
        if (readValid) pending--;
        #2;
        read = 1'b0;
        write = 1'b0;
        checkIrq = 1'b0;
        testName = e.name;
        address = e.addr;
        dataIn = e.data;
        expWord = e.expected;
        case (e.op)
            OP_WRITE: write = 1'b1;
            OP_IRQ:   checkIrq = 1'b1;
            OP_PULSE: refPulses(e.data);
            default: begin
                read = 1'b1;
                pending++;
                if (e.op == OP_READ) waitReads();
            end
        endcase
    endtask

    task automatic buildTable();
        // reset values, read back to back
        for (int i = 0; i < 8; i++)
            addRow({"reset addr ", 8'(8'h30 + i)}, (i < 7) ? OP_READB : OP_READ, i, 0, 0);
        for (int i = 0; i < 3; i++)
            addRow({"reset irq ", 8'(8'h30 + i)}, OP_IRQ, i, 0, 0);
        for (int i = 0; i < 6; i++) begin
            rnd[i] = $random(seed);
            addRow({"write ", 8'(8'h30 + i)}, OP_WRITE, i, rnd[i], 0);
        end
        for (int i = 0; i < 6; i++)
            addRow({"readback ", 8'(8'h30 + i)}, (i < 5) ? OP_READB : OP_READ, i, 0, rnd[i]);
        addRow("enable all", OP_WRITE, 6, 32'hffffffff, 0);
        addRow("enable read", OP_READB, 6, 0, 7);
        addRow("unused addr", OP_READ, 7, 0, 0);
        for (int i = 0; i < 3; i++)
            addRow("count set", OP_WRITE, i, 10, 0);
        addRow("count pulses", OP_PULSE, 0, 4, 0);
        for (int i = 0; i < 3; i++)
            addRow({"count ", 8'(8'h30 + i)}, (i < 2) ? OP_READB : OP_READ, i, 0, 6);
        // channel 1 reloads on the third tick, 0 and 2 run through zero
        addRow("ch0 set", OP_WRITE, 0, 1, 0);
        addRow("ch1 set", OP_WRITE, 1, 2, 0);
        addRow("ch2 set", OP_WRITE, 2, 1, 0);
        addRow("ch1 reload", OP_WRITE, 4, 5, 0);
        addRow("enable ch1", OP_WRITE, 6, 2, 0);
        addRow("reload pulses", OP_PULSE, 0, 3, 0);
        addRow("ch0 wrapped", OP_READB, 0, 0, countAfter(1, rnd[3], 3));
        addRow("ch1 reloaded", OP_READB, 1, 0, countAfter(2, 5, 3));
        addRow("ch2 wrapped", OP_READ, 2, 0, countAfter(1, rnd[5], 3));
        for (int i = 0; i < 3; i++)
            addRow({"irq ch ", 8'(8'h30 + i)}, OP_IRQ, i, 0, (i == 1) ? 1 : 0);
        // reload with every interrupt disabled
        addRow("enable off", OP_WRITE, 6, 0, 0);
        addRow("ch2 zero", OP_WRITE, 2, 0, 0);
        addRow("ch2 reload", OP_WRITE, 5, 9, 0);
        addRow("quiet pulse", OP_PULSE, 0, 1, 0);
        addRow("ch2 quiet", OP_READ, 2, 0, 9);
        addRow("irq ch2 quiet", OP_IRQ, 2, 0, 0);
    endtask

    initial begin
        seed = 63;
        reset = 1'b1;
        read = 1'b0;
        write = 1'b0;
        refClk = 1'b0;
        checkIrq = 1'b0;
        address = '0;
        dataIn = '0;
        expWord = '0;
        testName = '0;
        pending = 0;
        timeouts = 0;
        buildTable();
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        foreach (stimTable[i]) runEntry(stimTable[i]);
        @(posedge clk);
        #2;
        read = 1'b0;
        write = 1'b0;
        checkIrq = 1'b0;
        repeat (3) @(posedge clk);
        $display("checks passed %0d, failed %0d, timeouts %0d", passCount, failCount, timeouts);
        if (failCount == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/timerChecker.sv */
//**********************************************************************
// testbench checker for the timer peripheral
// read data compare, readValid latency check, irq pulse counting
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

module timerChecker (
    input  logic                clk,
    input  logic                reset,
    input  logic                read,
    input  logic                readValid,
    input  regMapPkg::busWord_t dataOut,
    input  timerPkg::irqVec_t   irq,
    input  logic                checkIrq,
    input  logic [1:0]          chan,
    input  logic [127:0]        testName,
    input  regMapPkg::busWord_t expWord,
    output int                  passCount,
    output int                  failCount
);

    logic [1:0]          readPipe;
    logic [127:0]        namePipe [2];
    regMapPkg::busWord_t expPipe [2];
    int                  irqCount [timerPkg::NUM_TIMERS];

    task automatic report(input logic [127:0] name, input logic [31:0] expected,
                          input logic [31:0] actual);
        if (expected === actual) begin
            passCount++;
            $display("ok       %0s  0x%08h", name, actual);
        end else begin
            failCount++;
            $display("** Error %0s  expected 0x%08h  actual 0x%08h", name, expected, actual);
        end
    endtask

    // name and expected word travel with the read request
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            passCount = 0;
            failCount = 0;
            readPipe <= '0;
            irqCount <= '{default: 0};
        end else begin
            readPipe    <= {readPipe[0], read};
            namePipe[0] <= testName;
            namePipe[1] <= namePipe[0];
            expPipe[0]  <= expWord;
            expPipe[1]  <= expPipe[0];
            if (readValid !== readPipe[1]) begin
                failCount++;
                $display("readValid did not follow a read request by two cycles");
            end
            if (readValid) begin
                report(namePipe[1], expPipe[1], dataOut);
            end
            for (int i = 0; i < timerPkg::NUM_TIMERS; i++) begin
                if (irq[i]) begin
                    irqCount[i] <= irqCount[i] + 1;
                end
            end
            // compare and restart the pulse count of one channel
            if (checkIrq) begin
                report(testName, expWord, irqCount[chan]);
                irqCount[chan] <= 0;
            end
        end
    end

endmodule

`default_nettype wire
